//--- compile.f
src/game_input_pkg.sv
src/ps2_rx.sv
src/scancode_framer.sv
src/key_decoder.sv
src/player_motion.sv
src/game_input_top.sv
verif/game_input_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and fails if the log reports a failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module game_input_tb -o game_input_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/game_input_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

exit 0

//--- verif/game_input_tb.sv
// Testbench for game_input_top; plays a table of PS/2 frames and ticks and checks every output
`default_nettype none

module game_input_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic clk;
    logic rst;
    logic ps2_clk;
    logic ps2_data;
    logic frame_tick;
    game_input_pkg::key_state_t  keys;
    game_input_pkg::player_pos_t pos;
    logic rx_error;

    // Stimulus table, one entry per test in every queue
    string                       row_name[$];
    int                          row_nbytes[$];
    logic [23:0]                 row_bytes[$];      // First byte in the top eight bits
    logic                        row_bad_parity[$]; // Corrupts the last byte of the row
    int                          row_ticks[$];
    logic                        row_reset[$];
    game_input_pkg::key_state_t  row_keys[$];
    game_input_pkg::player_pos_t row_pos[$];
    int                          row_errors[$];     // Running total of rx_error pulses

    int          mx;
    int          my;
    int          mvel;
    logic        mair;
    logic [31:0] lcg_state;
    int          err_count = 0;
    int          pass_count;
    int          fail_count;
    int          limit_cycles;
    logic        test_bad;

    game_input_top u_game_input_top (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .frame_tick (frame_tick),
        .keys       (keys),
        .pos        (pos),
        .rx_error   (rx_error)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        if (rx_error) begin
            err_count <= err_count + 1;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic add_row(input string name, input int nbytes, input logic [23:0] bytes,
                           input logic bad, input int ticks, input logic do_reset,
                           input logic [2:0] k, input int errs);
        row_name.push_back(name);
        row_nbytes.push_back(nbytes);
        row_bytes.push_back(bytes);
        row_bad_parity.push_back(bad);
        row_ticks.push_back(ticks);
        row_reset.push_back(do_reset);
        row_keys.push_back(game_input_pkg::key_state_t'(k));
        row_pos.push_back('0);
        row_errors.push_back(errs);
    endtask

    // Reference motion: walk with clamping, launch on the ground, then rise and fall by gravity
    task automatic model_tick(input game_input_pkg::key_state_t k);
        int nx;
        nx = mx;
        if (k.right && !k.left) begin
            nx = mx + int'(game_input_pkg::WALK_STEP);
            if (nx > int'(game_input_pkg::X_MAX)) begin
                nx = int'(game_input_pkg::X_MAX);
            end
        end else if (k.left && !k.right) begin
            nx = mx - int'(game_input_pkg::WALK_STEP);
            if (nx < 0) begin
                nx = 0;
            end
        end
        if (!mair) begin
            if (k.jump) begin
                mair = 1'b1;
                mvel = int'(game_input_pkg::JUMP_SPEED); // Height starts to change on the next tick
            end
        end else if (my + mvel <= 0) begin
            my   = 0;
            mair = 1'b0;
            mvel = 0;
        end else begin
            my   = my + mvel;
            mvel = mvel - int'(game_input_pkg::GRAVITY);
        end
        mx = nx;
    endtask

    task automatic fill_expected();
        game_input_pkg::player_pos_t p;
        int r;
        int t;
        int lim;
        mx = 0;
        my = 0;
        mvel = 0;
        mair = 1'b0;
        lim = 16;
        for (r = 0; r < row_name.size(); r++) begin
            if (row_reset[r]) begin
                mx = 0;
                my = 0;
                mvel = 0;
                mair = 1'b0;
            end
            for (t = 0; t < row_ticks[r]; t++) begin
                model_tick(row_keys[r]);
            end
            p.x        = 10'(mx);
            p.y        = 9'(my);
            p.airborne = mair;
            row_pos[r] = p;
            // Frame time with the longest idle gap, settle time, ticks and a reset
            lim += row_nbytes[r] * (11 * 10 + 83) + 10 + row_ticks[r] * 4 + 9;
        end
        limit_cycles = lim * 2;
    endtask

    // Start bit, data LSB first, odd parity and stop bit; data changes while ps2_clk is high
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] frame;
        int i;
        frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            wait_cycles(5);
            ps2_clk = 1'b0;
            wait_cycles(5);
            ps2_clk = 1'b1;
        end
        lcg_state = lcg_next(lcg_state);
        wait_cycles(20 + int'(lcg_state[21:16])); // Idle gap of 20 to 83 cycles
    endtask

    task automatic issue_tick();
        frame_tick = 1'b1;
        wait_cycles(1);
        frame_tick = 1'b0;
        wait_cycles(3);
    endtask

    task automatic check_keys(input string name, input game_input_pkg::key_state_t exp,
                              input game_input_pkg::key_state_t act);
        if (act !== exp) begin
            $display("[FAIL] %s keys expected %b actual %b", name, exp, act);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_pos(input string name, input game_input_pkg::player_pos_t exp,
                             input game_input_pkg::player_pos_t act);
        if (act !== exp) begin
            $display("[FAIL] %s pos expected x=%0d y=%0d air=%b actual x=%0d y=%0d air=%b",
                     name, exp.x, exp.y, exp.airborne, act.x, act.y, act.airborne);
            test_bad = 1'b1;
        end
    endtask

    task automatic check_errors(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s rx_error count expected %0d actual %0d", name, exp, act);
            test_bad = 1'b1;
        end
    endtask

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", limit_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int r;
        int b;
        clk = 1'b0;
        rst = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        frame_tick = 1'b0;
        pass_count = 0;
        fail_count = 0;
        limit_cycles = 0;
        lcg_state = 32'h2bb6_6f79;

        // Keys are right, left, jump from the top bit down
        add_row("right_make",        1, 24'h1C0000, 1'b0,   3, 1'b0, 3'b100, 0);
        add_row("other_key",         1, 24'h1B0000, 1'b0,   1, 1'b0, 3'b100, 0);
        add_row("right_break",       2, 24'hF01C00, 1'b0,   1, 1'b0, 3'b000, 0);
        add_row("left_make_clamp",   1, 24'h230000, 1'b0,   5, 1'b0, 3'b010, 0);
        add_row("left_break",        2, 24'hF02300, 1'b0,   0, 1'b0, 3'b000, 0);
        add_row("jump_make",         1, 24'h1D0000, 1'b0,   0, 1'b0, 3'b001, 0);
        add_row("jump_break",        2, 24'hF01D00, 1'b0,   0, 1'b0, 3'b000, 0);
        add_row("arrow_right_clamp", 2, 24'hE07400, 1'b0, 160, 1'b0, 3'b100, 0);
        add_row("arrow_right_break", 3, 24'hE0F074, 1'b0,   0, 1'b0, 3'b000, 0);
        add_row("arrow_left_make",   2, 24'hE06B00, 1'b0,   2, 1'b0, 3'b010, 0);
        add_row("both_held",         1, 24'h1C0000, 1'b0,   4, 1'b0, 3'b110, 0);
        add_row("arrow_left_break",  3, 24'hE0F06B, 1'b0,   0, 1'b0, 3'b100, 0);
        add_row("right_release",     2, 24'hF01C00, 1'b0,   0, 1'b0, 3'b000, 0);
        add_row("arrow_up_rise",     2, 24'hE07500, 1'b0,  10, 1'b0, 3'b001, 0);
        add_row("arrow_up_land",     3, 24'hE0F075, 1'b0,  30, 1'b0, 3'b000, 0);
        add_row("letter_with_ext",   2, 24'hE01C00, 1'b0,   1, 1'b0, 3'b000, 0);
        add_row("arrow_without_ext", 1, 24'h740000, 1'b0,   1, 1'b0, 3'b000, 0);
        add_row("parity_error",      1, 24'h1D0000, 1'b1,   1, 1'b0, 3'b000, 1);
        add_row("after_error",       1, 24'h1D0000, 1'b0,   3, 1'b0, 3'b001, 1);
        add_row("reset",             0, 24'h000000, 1'b0,   0, 1'b1, 3'b000, 1);
        add_row("break_no_make",     2, 24'hF02300, 1'b0,   2, 1'b0, 3'b000, 1);
        fill_expected();

        wait_cycles(8);
        rst = 1'b0;
        wait_cycles(2);

        for (r = 0; r < row_name.size(); r++) begin
            test_bad = 1'b0;
            if (row_reset[r]) begin
                rst = 1'b1;
                wait_cycles(8);
                rst = 1'b0;
                wait_cycles(1);
            end
            for (b = 0; b < row_nbytes[r]; b++) begin
                send_frame(row_bytes[r][23 - 8 * b -: 8],
                           row_bad_parity[r] && (b == row_nbytes[r] - 1));
            end
            wait_cycles(10);
            repeat (row_ticks[r]) issue_tick();
            check_keys(row_name[r], row_keys[r], keys);
            check_pos(row_name[r], row_pos[r], pos);
            check_errors(row_name[r], row_errors[r], err_count);
            if (test_bad) begin
                fail_count++;
            end else begin
                pass_count++;
                $display("[PASS] %s", row_name[r]);
            end
        end

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/game_input_top.sv
// Top level of the input path: PS/2 receiver, prefix framer, key decoder and player motion
`default_nettype none

module game_input_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ps2_clk,
    input  logic                        ps2_data,
    input  logic                        frame_tick,
    output game_input_pkg::key_state_t  keys,
    output game_input_pkg::player_pos_t pos,
    output logic                        rx_error
);

    game_input_pkg::ps2_byte_t   rx_byte;       // Raw bytes, prefixes included
    game_input_pkg::scan_event_t scan_event;    // Prefix-free key events

    ps2_rx u_ps2_rx (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_byte  (rx_byte),
        .rx_error (rx_error)
    );

    scancode_framer u_scancode_framer (
        .clk        (clk),
        .rst        (rst),
        .rx_byte    (rx_byte),
        .scan_event (scan_event)
    );

    key_decoder u_key_decoder (
        .clk        (clk),
        .rst        (rst),
        .scan_event (scan_event),
        .keys       (keys)
    );

    // Keys are sampled on the tick itself
    player_motion u_player_motion (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick),
        .keys       (keys),
        .pos        (pos)
    );

endmodule

`default_nettype wire

//--- src/player_motion.sv
// Moves the player once per frame tick: clamped walking and a simple gravity jump
`default_nettype none

module player_motion (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        frame_tick,
    input  game_input_pkg::key_state_t  keys,
    output game_input_pkg::player_pos_t pos
);

    logic signed [game_input_pkg::VEL_W-1:0] vel;  // Upward speed, goes negative on the way down

    logic [10:0]        x_right;    // One spare bit so the right clamp sees the overflow
    logic [9:0]         x_next;
    logic signed [10:0] y_sum;
    logic               walk_right;
    logic               walk_left;

    // Holding both directions cancels out
    assign walk_right = keys.right & ~keys.left;
    assign walk_left  = keys.left & ~keys.right;

    assign x_right = {1'b0, pos.x} + {1'b0, game_input_pkg::WALK_STEP};

    always_comb begin
        if (walk_right) begin
            if (x_right > {1'b0, game_input_pkg::X_MAX}) begin
                x_next = game_input_pkg::X_MAX;
            end else begin
                x_next = x_right[9:0];
            end
        end else if (walk_left) begin
            if (pos.x < game_input_pkg::WALK_STEP) begin
                x_next = '0; // Left wall
            end else begin
                x_next = pos.x - game_input_pkg::WALK_STEP;
            end
        end else begin
            x_next = pos.x;
        end
    end

    // Height after this tick, with the velocity sign-extended to the sum width
    assign y_sum = $signed({2'b00, pos.y})
                 + $signed({{(11 - game_input_pkg::VEL_W){vel[game_input_pkg::VEL_W-1]}}, vel});

    // The launch tick only sets the speed; the player rises from the next tick on
    always_ff @(posedge clk) begin
        if (rst) begin
            pos <= '0;
            vel <= '0;
        end else if (frame_tick) begin
            pos.x <= x_next;

            if (!pos.airborne) begin
                if (keys.jump) begin
                    pos.airborne <= 1'b1;
                    vel          <= game_input_pkg::JUMP_SPEED;
                end
            end else if (y_sum <= 11'sd0) begin
                // Landed, so snap to the ground and stop
                pos.y        <= '0;
                pos.airborne <= 1'b0;
                vel          <= '0;
            end else begin
                pos.y <= y_sum[8:0];
                vel   <= vel - game_input_pkg::GRAVITY; // Slows the climb, then speeds the fall
            end
        end
    end

endmodule

`default_nettype wire

//--- src/key_decoder.sv
// Keeps the right, left and jump key levels from make and break scan events
`default_nettype none

module key_decoder (
    input  logic                        clk,
    input  logic                        rst,
    input  game_input_pkg::scan_event_t scan_event,
    output game_input_pkg::key_state_t  keys
);

    logic hit_right;
    logic hit_left;
    logic hit_jump;

    // Letter keys only count without E0 and arrow keys only with it
    always_comb begin
        hit_right = 1'b0;
        hit_left  = 1'b0;
        hit_jump  = 1'b0;

        if (scan_event.ext) begin
            case (scan_event.code)
                game_input_pkg::ARROW_RIGHT: hit_right = 1'b1;
                game_input_pkg::ARROW_LEFT:  hit_left  = 1'b1;
                game_input_pkg::ARROW_UP:    hit_jump  = 1'b1;
                default: ;                          // Other extended keys are ignored
            endcase
        end else begin
            case (scan_event.code)
                game_input_pkg::KEY_RIGHT: hit_right = 1'b1;
                game_input_pkg::KEY_LEFT:  hit_left  = 1'b1;
                game_input_pkg::KEY_JUMP:  hit_jump  = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            keys <= '0;
        end else if (scan_event.valid) begin
            // A make raises the level, a break drops it
            if (hit_right) begin
                keys.right <= scan_event.make;
            end
            if (hit_left) begin
                keys.left <= scan_event.make;
            end
            if (hit_jump) begin
                keys.jump <= scan_event.make;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/scancode_framer.sv
// Folds the F0 break and E0 extended prefixes into the following code byte as one scan event
`default_nettype none

module scancode_framer (
    input  logic                        clk,
    input  logic                        rst,
    input  game_input_pkg::ps2_byte_t   rx_byte,
    output game_input_pkg::scan_event_t scan_event
);

    logic break_flag;   // F0 seen since the last code byte
    logic ext_flag;     // E0 seen since the last code byte
    logic is_break;
    logic is_ext;

    assign is_break = (rx_byte.data == game_input_pkg::BREAK_PREFIX);
    assign is_ext   = (rx_byte.data == game_input_pkg::EXT_PREFIX);

    always_ff @(posedge clk) begin
        if (rst) begin
            break_flag <= 1'b0;
            ext_flag   <= 1'b0;
            scan_event <= '0;
        end else begin
            scan_event.valid <= 1'b0;

            if (rx_byte.valid) begin
                if (is_break) begin
                    break_flag <= 1'b1;
                end else if (is_ext) begin
                    ext_flag <= 1'b1;
                end else begin
                    // Extended breaks arrive as E0 F0 xx, so both flags can be set here
                    scan_event.valid <= 1'b1;
                    scan_event.make  <= ~break_flag;
                    scan_event.ext   <= ext_flag;
                    scan_event.code  <= rx_byte.data;
                    break_flag       <= 1'b0;
                    ext_flag         <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ps2_rx.sv
// PS/2 device-to-host receiver; strobes each good byte and flags parity or stop-bit errors
`default_nettype none

module ps2_rx (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      ps2_clk,
    input  logic                      ps2_data,
    output game_input_pkg::ps2_byte_t rx_byte,
    output logic                      rx_error
);

    logic ps2_clk_meta;
    logic ps2_clk_sync;
    logic ps2_clk_prev;
    logic ps2_data_meta;
    logic ps2_data_sync;
    logic clk_fall;

    logic [3:0]  bit_cnt;       // Number of bits taken so far in the current frame
    logic [9:0]  shreg;         // Start, data and parity bits, LSB arrives first
    logic [15:0] idle_cnt;
    logic        parity_ok;
    logic        stop_ok;
    logic        timeout;

    // Both lines idle high, so the synchronizers come out of reset at 1
    always_ff @(posedge clk) begin
        if (rst) begin
            ps2_clk_meta  <= 1'b1;
            ps2_clk_sync  <= 1'b1;
            ps2_clk_prev  <= 1'b1;
            ps2_data_meta <= 1'b1;
            ps2_data_sync <= 1'b1;
        end else begin
            ps2_clk_meta  <= ps2_clk;
            ps2_clk_sync  <= ps2_clk_meta;
            ps2_clk_prev  <= ps2_clk_sync;
            ps2_data_meta <= ps2_data;
            ps2_data_sync <= ps2_data_meta;
        end
    end

    assign clk_fall = ps2_clk_prev & ~ps2_clk_sync;

    // Data bits and parity together must hold an odd number of ones
    assign parity_ok = ^shreg[9:1];
    assign stop_ok   = ps2_data_sync;
    assign timeout   = (idle_cnt == game_input_pkg::RX_TIMEOUT_CYCLES - 16'd1);

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
            rx_byte  <= '0;
            rx_error <= 1'b0;
        end else begin
            rx_byte.valid <= 1'b0;
            rx_error      <= 1'b0;

            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd0) begin
                    // A high level here is not a start bit, so stay idle
                    if (!ps2_data_sync) begin
                        bit_cnt <= 4'd1;
                    end
                end else if (bit_cnt == 4'd10) begin
                    bit_cnt <= '0; // Stop bit, frame is complete
                    if (parity_ok && stop_ok) begin
                        rx_byte.valid <= 1'b1;
                        rx_byte.data  <= shreg[8:1];
                    end else begin
                        rx_error <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt == 4'd0) begin
                idle_cnt <= '0;
            end else if (timeout) begin
                // Keyboard went quiet in mid-frame; throw the partial frame away
                bit_cnt  <= '0;
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 16'd1;
            end
        end
    end

    // Every sampled bit except the stop bit shifts in from the top
    always_ff @(posedge clk) begin
        if (clk_fall && bit_cnt != 4'd10) begin
            shreg <= {ps2_data_sync, shreg[9:1]};
        end
    end

endmodule

`default_nettype wire

//--- src/game_input_pkg.sv
// Shared types, PS/2 key codes and motion constants for the keyboard-to-player input path
`default_nettype none

package game_input_pkg;

    // One byte as it leaves the PS/2 receiver
    typedef struct packed {
        logic       valid;                      // One-cycle strobe
        logic [7:0] data;                       // Meaningful only while valid is high
    } ps2_byte_t;

    // One complete key event after the prefix bytes are folded in
    typedef struct packed {
        logic       valid;
        logic       make;                       // Cleared for a break (key released)
        logic       ext;                        // Set when the code came after E0
        logic [7:0] code;
    } scan_event_t;

    // Held-key levels, always valid
    typedef struct packed {
        logic right;
        logic left;
        logic jump;
    } key_state_t;

    // Player position, y counts upward from the ground
    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
        logic       airborne;
    } player_pos_t;

    // Scan code set 2 prefixes
    localparam logic [7:0] BREAK_PREFIX = 8'hF0;
    localparam logic [7:0] EXT_PREFIX   = 8'hE0;

    // Letter keys used by the game
    localparam logic [7:0] KEY_RIGHT = 8'h1C;       // A
    localparam logic [7:0] KEY_LEFT  = 8'h23;       // D
    localparam logic [7:0] KEY_JUMP  = 8'h1D;       // W

    // Arrow keys, only valid after the E0 prefix
    localparam logic [7:0] ARROW_RIGHT = 8'h74;
    localparam logic [7:0] ARROW_LEFT  = 8'h6B;
    localparam logic [7:0] ARROW_UP    = 8'h75;

    // Partial frame is dropped after this many clk cycles without a ps2_clk falling edge
    localparam logic [15:0] RX_TIMEOUT_CYCLES = 16'd2000;

    // Player motion
    localparam int VEL_W = 6;                       // Signed vertical velocity width
    localparam logic [9:0] X_MAX = 10'd600;         // Right edge of the playfield
    localparam logic [9:0] WALK_STEP = 10'd4;
    localparam logic signed [VEL_W-1:0] JUMP_SPEED = 6'sd12;
    localparam logic signed [VEL_W-1:0] GRAVITY = 6'sd1;

endpackage

`default_nettype wire
